/* Bender.yml */
package:
  name: bch_decoder

sources:
  - include_dirs:
      - hw
    files:
      - hw/bch_pkg.sv
      - hw/bch_syndrome.sv
      - hw/bch_key_solver.sv
      - hw/bch_delay_line.sv
      - hw/bch_chien_corrector.sv
      - hw/bch_decoder.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verification/bch_decoder_tb.sv

/* filelist.f */
+incdir+hw
hw/bch_pkg.sv
hw/bch_syndrome.sv
hw/bch_key_solver.sv
hw/bch_delay_line.sv
hw/bch_chien_corrector.sv
hw/bch_decoder.sv
verification/bch_decoder_tb.sv

/* hw/bch_chien_corrector.sv */
`default_nettype none

`include "bch_defs.svh"

module bch_chien_corrector
	import bch_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire           loc_valid,
	input  wire locator_t locator,
	input  wire degree_t  loc_degree,
	input  wire beat_t    delayed_beat,
	output out_beat_t     out_beat
);

	localparam int T = `BCH_T;
	localparam int CW = $clog2(`BCH_N + 1);      // Root counter width.

	locator_t term_q;                            // Lambda_i * alpha^(i*k).
	locator_t term_cur;
	locator_t term_nxt;
	degree_t deg_q;
	degree_t deg_cur;
	logic [CW-1:0] roots_q;
	logic [CW-1:0] roots_cur;                    // Roots including this beat.
	gf_t eval;
	logic is_root;

	// The first beat comes with loc_valid, so it is evaluated from the input.
	always_comb begin
		eval = '0;
		for (int i = 0; i <= T; i++) begin
			if (loc_valid)
				term_cur[i] = gf_mul(locator[i], gf_alpha_pow(i)); // Lambda(alpha^1).
			else
				term_cur[i] = term_q[i];
			eval ^= term_cur[i];
			term_nxt[i] = gf_mul(term_cur[i], gf_alpha_pow(i));  // One position lower.
		end
	end

	assign is_root = delayed_beat.valid && (eval == '0);
	assign deg_cur = loc_valid ? loc_degree : deg_q;
	assign roots_cur = (delayed_beat.first ? '0 : roots_q) + CW'(is_root);

	always_ff @(posedge clk) begin
		if (loc_valid)
			deg_q <= loc_degree;
		if (delayed_beat.valid) begin
			term_q <= term_nxt;
			roots_q <= roots_cur;
		end
	end

	always_ff @(posedge clk) begin
		out_beat.first <= delayed_beat.first;
		out_beat.last <= delayed_beat.last;
		out_beat.data <= delayed_beat.data ^ is_root;   // Flip at a root.
		// Missing roots or too many errors.
		out_beat.uncorrectable <= delayed_beat.last &&
			((roots_cur != CW'(deg_cur)) || (int'(deg_cur) > T));
		if (rst)
			out_beat.valid <= 1'b0;
		else
			out_beat.valid <= delayed_beat.valid;
	end

endmodule

`default_nettype wire

/* hw/bch_decoder.sv */
`default_nettype none

module bch_decoder
	import bch_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire beat_t in_beat,
	output out_beat_t  out_beat
);

	logic syn_valid;
	syndromes_t syndromes;
	logic loc_valid;
	locator_t locator;
	degree_t loc_degree;
	beat_t delayed_beat;                 // Bits waiting for their locator.

	bch_syndrome u_syndrome (
		.clk       (clk),
		.rst       (rst),
		.in_beat   (in_beat),
		.syn_valid (syn_valid),
		.syndromes (syndromes)
	);

	bch_key_solver u_key_solver (
		.clk        (clk),
		.rst        (rst),
		.syn_valid  (syn_valid),
		.syndromes  (syndromes),
		.loc_valid  (loc_valid),
		.locator    (locator),
		.loc_degree (loc_degree)
	);

	bch_delay_line u_delay_line (
		.clk          (clk),
		.rst          (rst),
		.in_beat      (in_beat),
		.delayed_beat (delayed_beat)
	);

	// Locator and first delayed bit meet here.
	bch_chien_corrector u_chien_corrector (
		.clk          (clk),
		.rst          (rst),
		.loc_valid    (loc_valid),
		.locator      (locator),
		.loc_degree   (loc_degree),
		.delayed_beat (delayed_beat),
		.out_beat     (out_beat)
	);

endmodule

`default_nettype wire

/* hw/bch_defs.svh */
`ifndef BCH_DEFS_SVH
`define BCH_DEFS_SVH

// Field degree, GF(2^M).
`define BCH_M 4

// Correctable bit errors per codeword.
`define BCH_T 2

// Code length of a primitive code.
`define BCH_N ((1 << `BCH_M) - 1)

// Message length of the default BCH(15,7) code.
`define BCH_K 7

// Field polynomial x^4+x+1 without the x^M term, M bits wide.
`define BCH_POLY 4'b0011

// Input to output beat delay of the decoder.
// Delay line N+2T+1 plus the corrector output register.
`define BCH_LATENCY (`BCH_N + 2 * `BCH_T + 2)

`endif

/* hw/bch_delay_line.sv */
`default_nettype none

`include "bch_defs.svh"

module bch_delay_line
	import bch_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire beat_t in_beat,
	output beat_t      delayed_beat
);

	// Covers the syndrome, load and 2T solver cycles.
	localparam int DEPTH = `BCH_N + 2 * `BCH_T + 1;

	beat_t stage [DEPTH];

	always_ff @(posedge clk) begin
		stage[0] <= in_beat;
		for (int i = 1; i < DEPTH; i++) begin
			stage[i] <= stage[i-1];
		end
		// Only the valid bits are cleared.
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i].valid <= 1'b0;
			end
		end
	end

	assign delayed_beat = stage[DEPTH-1];

endmodule

`default_nettype wire

/* hw/bch_key_solver.sv */
`default_nettype none

`include "bch_defs.svh"

module bch_key_solver
	import bch_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             syn_valid,
	input  wire syndromes_t syndromes,
	output logic            loc_valid,
	output locator_t        locator,
	output degree_t         loc_degree
);

	localparam int T = `BCH_T;
	localparam int RW = $clog2(2 * T);           // Iteration counter width.
	localparam int LW = $clog2(2 * T + 1);       // Register length width.
	localparam logic [RW-1:0] LAST_ROUND = RW'(2 * T - 1);
	localparam locator_t POLY_ONE = locator_t'(1);

	logic busy;
	logic [RW-1:0] round;
	logic [LW-1:0] len;                          // Register length L.
	syndromes_t syn_q;
	locator_t lambda_q;                          // Current locator.
	locator_t corr_q;                            // Correction polynomial B(x).
	gf_t gamma_q;                                // Previous discrepancy.
	gf_t delta;
	logic grow;
	locator_t lambda_d;
	locator_t corr_d;

	// Discrepancy of round r, sum of lambda_i * S(r+1-i).
	always_comb begin
		delta = '0;
		for (int i = 0; i <= T; i++) begin
			if (i <= int'(round))
				delta ^= gf_mul(lambda_q[i], syn_q[int'(round) - i]);
		end
	end

	// The length grows when the discrepancy is nonzero and 2L <= r.
	assign grow = (delta != '0) && (2 * int'(len) <= int'(round));

	// Lambda <= gamma*Lambda + delta*x*B, no inversion needed.
	always_comb begin
		for (int i = 0; i <= T; i++) begin
			if (i == 0) begin
				lambda_d[i] = gf_mul(gamma_q, lambda_q[i]);
				corr_d[i] = grow ? lambda_q[i] : '0;
			end else begin
				lambda_d[i] = gf_mul(gamma_q, lambda_q[i]) ^ gf_mul(delta, corr_q[i-1]);
				corr_d[i] = grow ? lambda_q[i] : corr_q[i-1];
			end
		end
	end

	// Polynomial state, loaded from the syndromes and then iterated.
	always_ff @(posedge clk) begin
		if (syn_valid) begin
			syn_q <= syndromes;
			lambda_q <= POLY_ONE;
			corr_q <= POLY_ONE;
			gamma_q <= gf_t'(1);
			len <= '0;
		end else if (busy) begin
			lambda_q <= lambda_d;
			corr_q <= corr_d;
			if (grow) begin
				gamma_q <= delta;
				len <= LW'(int'(round) + 1 - int'(len));
			end
		end
	end

	// Sequencer. 2T rounds follow the load cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			round <= '0;
			loc_valid <= 1'b0;
		end else begin
			loc_valid <= busy && (round == LAST_ROUND);
			if (syn_valid) begin
				busy <= 1'b1;
				round <= '0;
			end else if (busy) begin
				round <= round + 1'b1;
				if (round == LAST_ROUND)
					busy <= 1'b0;
			end
		end
	end

	assign locator = lambda_q;

	// More than T errors show up as T+1.
	assign loc_degree = (int'(len) > T) ? degree_t'(T + 1) : degree_t'(len);

endmodule

`default_nettype wire

/* hw/bch_pkg.sv */
`default_nettype none

`include "bch_defs.svh"

package bch_pkg;

	// One element of GF(2^M).
	typedef logic [`BCH_M-1:0] gf_t;

	// Index 0 holds S1, index 2T-1 holds S2T.
	typedef gf_t [2*`BCH_T-1:0] syndromes_t;

	// Error locator, coefficient 0 first.
	typedef gf_t [`BCH_T:0] locator_t;

	// Register length L, wide enough to show T+1.
	typedef logic [$clog2(`BCH_T + 2)-1:0] degree_t;

	// One received bit with its framing.
	typedef struct packed {
		logic valid;
		logic first;                       // First bit of a codeword.
		logic last;                        // Last bit of a codeword.
		logic data;
	} beat_t;

	// Corrected bit; uncorrectable only means something on last.
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
		logic data;
		logic uncorrectable;
	} out_beat_t;

	// Shift-and-add product of two field elements.
	function automatic gf_t gf_mul(gf_t a, gf_t b);
		gf_t prod;
		gf_t shifted;
		prod = '0;
		shifted = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				prod ^= shifted;
			// Multiply by x and reduce.
			if (shifted[`BCH_M-1])
				shifted = {shifted[`BCH_M-2:0], 1'b0} ^ gf_t'(`BCH_POLY);
			else
				shifted = {shifted[`BCH_M-2:0], 1'b0};
		end
		return prod;
	endfunction

	// Alpha^e for any integer e, negative ones included.
	function automatic gf_t gf_alpha_pow(int e);
		gf_t acc;
		int k;
		acc = gf_t'(1);
		k = e % `BCH_N;
		if (k < 0)
			k += `BCH_N;                     // Alpha^N is one.
		for (int i = 0; i < `BCH_N; i++) begin
			if (i < k)
				acc = gf_mul(acc, gf_t'(2));   // Alpha is the element x.
		end
		return acc;
	endfunction

endpackage

`default_nettype wire

/* hw/bch_syndrome.sv */
`default_nettype none

`include "bch_defs.svh"

module bch_syndrome
	import bch_pkg::*;
(
	input  wire        clk,
	input  wire        rst,
	input  wire beat_t in_beat,
	output logic       syn_valid,
	output syndromes_t syndromes
);

	localparam int T = `BCH_T;

	syndromes_t acc_q;                   // Running Horner sums.
	syndromes_t acc_d;

	// Sj = r(alpha^j), highest coefficient arrives first.
	always_comb begin
		for (int j = 0; j < 2 * T; j++) begin
			if (in_beat.first)
				acc_d[j] = gf_t'(in_beat.data);            // Restart the sum.
			else
				acc_d[j] = gf_mul(acc_q[j], gf_alpha_pow(j + 1)) ^
					gf_t'(in_beat.data);
		end
	end

	always_ff @(posedge clk) begin
		if (in_beat.valid)
			acc_q <= acc_d;
		// Finished values stay until the next word ends.
		if (in_beat.valid && in_beat.last)
			syndromes <= acc_d;
	end

	always_ff @(posedge clk) begin
		if (rst)
			syn_valid <= 1'b0;
		else
			syn_valid <= in_beat.valid && in_beat.last;  // One-cycle strobe.
	end

endmodule

`default_nettype wire

/* verification/bch_decoder_tb.sv */
`default_nettype none

`include "bch_defs.svh"

module bch_decoder_tb
	import bch_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N = `BCH_N;
	localparam int LAT = `BCH_LATENCY;
	localparam int PW = `BCH_N - `BCH_K;         // Parity bits.
	localparam logic [PW:0] GEN = 9'h1d1;        // x^8+x^7+x^6+x^4+1.
	localparam int PERIOD = 40;
	localparam int GAP = 2;
	localparam int CLEAN_WORDS = 4;
	localparam int DOUBLE_WORDS = 6;
	localparam int STREAM_WORDS = 6;
	localparam int TRIPLE_WORDS = 5;
	localparam int NUM_TESTS = 6;
	localparam int TEST_BEATS =
		(CLEAN_WORDS + N + DOUBLE_WORDS + STREAM_WORDS + TRIPLE_WORDS) * (N + GAP);
	localparam int WATCHDOG_CYCLES = TEST_BEATS + NUM_TESTS * (LAT + 4) + 200;

	typedef logic [N-1:0] word_t;

	logic clk;
	logic rst;
	beat_t in_beat;
	out_beat_t out_beat;

	logic [31:0] lfsr;
	int cycle;
	int errors;
	int tests_run;
	int tests_failed;

	out_beat_t out_q[$];                         // Output beats as they appear.
	int out_cyc[$];
	int in_cyc[$];                               // Cycle each input was sampled.
	word_t exp_q[$];

	bch_decoder dut (
		.clk      (clk),
		.rst      (rst),
		.in_beat  (in_beat),
		.out_beat (out_beat)
	);

	initial begin
		clk = 1'b0;
		cycle = 0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	always @(posedge clk) begin
		if (out_beat.valid === 1'b1) begin
			out_q.push_back(out_beat);
			out_cyc.push_back(cycle);
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_step());
		return v;
	endfunction

	function automatic int rand_pos();
		int p;
		p = N;
		while (p >= N)
			p = rand_bits(`BCH_M);                   // Redraw the unused value.
		return p;
	endfunction

	// Polynomial long division by the generator.
	function automatic logic [PW-1:0] remainder(word_t w);
		word_t r;
		r = w;
		for (int i = N - 1; i >= PW; i--) begin
			if (r[i])
				r = r ^ (word_t'(GEN) << (i - PW));
		end
		return r[PW-1:0];
	endfunction

	// Systematic form, message in the top bits.
	function automatic word_t encode(logic [`BCH_K-1:0] msg);
		word_t shifted;
		shifted = word_t'(msg) << PW;
		return shifted | word_t'(remainder(shifted));
	endfunction

	function automatic word_t corrupt(word_t cw, int count);
		word_t mask;
		int p;
		mask = '0;
		for (int e = 0; e < count; e++) begin
			p = rand_pos();
			while (mask[p])
				p = rand_pos();
			mask[p] = 1'b1;
		end
		return cw ^ mask;
	endfunction

	function automatic word_t random_codeword();
		return encode(rand_bits(`BCH_K));
	endfunction

	task automatic check_beat(string name, out_beat_t want, out_beat_t got);
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s expected %b got %b", $time, name, want, got);
		end
	endtask

	task automatic check_word(string name, word_t want, word_t got);
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s expected %h got %h", $time, name, want, got);
		end
	endtask

	task automatic check_cycles(string name, int want, int got);
		if (got != want) begin
			errors++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, want, got);
		end
	endtask

	task automatic check_bit(string name, logic want, logic got);
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s expected %b got %b", $time, name, want, got);
		end
	endtask

	// MSB goes first, then gap idle cycles.
	task automatic send_word(word_t word, int gap);
		beat_t b;
		for (int i = 0; i < N; i++) begin
			@(posedge clk);
			b.valid = 1'b1;
			b.first = (i == 0);
			b.last = (i == N - 1);
			b.data = word[N-1-i];
			in_beat <= b;
			in_cyc.push_back(cycle + 1);
		end
		repeat (gap) begin
			@(posedge clk);
			in_beat <= '0;
		end
	endtask

	task automatic take_word(string name, output word_t word, output logic unc);
		out_beat_t got;
		out_beat_t want;
		int in_c;
		int out_c;
		word = '0;
		unc = 1'b0;
		for (int i = 0; i < N; i++) begin
			got = out_q.pop_front();
			out_c = out_cyc.pop_front();
			in_c = in_cyc.pop_front();
			word[N-1-i] = got.data;
			if (got.last)
				unc = got.uncorrectable;
			want = '0;
			want.valid = 1'b1;
			want.first = (i == 0);
			want.last = (i == N - 1);
			got.data = 1'b0;                         // Framing only here.
			got.uncorrectable = 1'b0;
			check_beat({name, " out_beat framing"}, want, got);
			check_cycles({name, " latency"}, LAT, out_c - in_c);
		end
	endtask

	task automatic collect_words(string name, int words, bit beyond_t);
		word_t got;
		word_t want;
		logic unc;
		int need;
		need = words * N;
		for (int k = 0; k < LAT + 4 && out_q.size() < need; k++)
			@(posedge clk);
		if (out_q.size() < need) begin
			errors++;
			$display("%s: only %0d of %0d output beats arrived in time",
				name, out_q.size(), need);
			out_q.delete();
			out_cyc.delete();
			in_cyc.delete();
			exp_q.delete();
			return;
		end
		for (int w = 0; w < words; w++) begin
			take_word(name, got, unc);
			want = exp_q.pop_front();
			if (beyond_t) begin
				// Unflagged output must at least be a codeword.
				if (unc !== 1'b1)
					check_word({name, " remainder"}, '0, word_t'(remainder(got)));
			end else begin
				check_word({name, " out_beat.data"}, want, got);
				check_bit({name, " out_beat.uncorrectable"}, 1'b0, unc);
			end
		end
	endtask

	task automatic report_test(string name, int errors_before);
		tests_run++;
		if (errors != errors_before)
			tests_failed++;
		$display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		@(posedge clk);
		for (int k = 0; k < LAT + 4; k++) begin
			@(posedge clk);
			if (k == 0)
				rst <= 1'b0;                         // Held over two edges.
			check_bit("out_beat.valid", 1'b0, out_beat.valid);
		end
		report_test("reset", e0);
	endtask

	task automatic test_clean();
		int e0;
		word_t cw;
		e0 = errors;
		for (int w = 0; w < CLEAN_WORDS; w++) begin
			cw = random_codeword();
			exp_q.push_back(cw);
			send_word(cw, GAP);
		end
		collect_words("clean words", CLEAN_WORDS, 1'b0);
		report_test("clean words", e0);
	endtask

	task automatic test_single();
		int e0;
		word_t cw;
		e0 = errors;
		for (int p = 0; p < N; p++) begin
			cw = random_codeword();
			exp_q.push_back(cw);
			send_word(cw ^ (word_t'(1) << p), GAP);
		end
		collect_words("single errors", N, 1'b0);
		report_test("single errors", e0);
	endtask

	task automatic test_double();
		int e0;
		word_t cw;
		e0 = errors;
		for (int w = 0; w < DOUBLE_WORDS; w++) begin
			cw = random_codeword();
			exp_q.push_back(cw);
			send_word(corrupt(cw, 2), GAP);
		end
		collect_words("double errors", DOUBLE_WORDS, 1'b0);
		report_test("double errors", e0);
	endtask

	// Back to back except the last word, which follows a gap.
	task automatic test_streaming();
		int e0;
		int gap;
		word_t cw;
		e0 = errors;
		for (int w = 0; w < STREAM_WORDS; w++) begin
			cw = random_codeword();
			exp_q.push_back(cw);
			gap = (w == STREAM_WORDS - 2) ? 5 : (w == STREAM_WORDS - 1) ? GAP : 0;
			send_word(corrupt(cw, w % 3), gap);
		end
		collect_words("streaming", STREAM_WORDS, 1'b0);
		report_test("streaming", e0);
	endtask

	task automatic test_triple();
		int e0;
		word_t cw;
		e0 = errors;
		for (int w = 0; w < TRIPLE_WORDS; w++) begin
			cw = random_codeword();
			exp_q.push_back(cw);
			send_word(corrupt(cw, 3), GAP);
		end
		collect_words("three errors", TRIPLE_WORDS, 1'b1);
		report_test("three errors", e0);
	endtask

	initial begin
		rst = 1'b1;
		in_beat = '0;
		lfsr = 32'hfe173ac4;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_reset();
		test_clean();
		test_single();
		test_double();
		test_streaming();
		test_triple();
		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire
